//--- common/spi_pkg.sv
/*
 * Shared definitions for the SPI register slave. Frames are fixed at 16 bits, MSB first.
 * The mode values are fixed here. Only mode 0 with an active-low CS is exercised by the testbench.
 */

package spi_pkg;

  // ************************************************************
  // Frame format
  // ************************************************************

  // Bits per frame and the width of a counter that can hold the full count
  localparam int frame_bits   = 16;
  localparam int bit_cnt_bits = $clog2(frame_bits + 1);

  // Command field widths
  localparam int addr_bits = 7;
  localparam int data_bits = 8;

  // Register file size and the index width into it
  localparam int reg_count      = 16;
  localparam int reg_index_bits = $clog2(reg_count);

  // ************************************************************
  // SPI mode
  // ************************************************************

  // Clock idle level, data phase and CS active level (mode 0, CS low)
  localparam logic cpol            = 1'b0;
  localparam logic cpha            = 1'b0;
  localparam logic cs_active_level = 1'b0;

  // MISO word sent when the previous frame was not a read
  localparam logic [frame_bits-1:0] default_miso_word = 16'hCAFE;

  // One command word, write flag in the MSB
  typedef struct packed {
    logic                 wr;
    logic [addr_bits-1:0] addr;
    logic [data_bits-1:0] data;
  } spi_cmd_t;

  // The received word seen either as shifted bits or as a command
  typedef union packed {
    logic [frame_bits-1:0] raw;
    spi_cmd_t              cmd;
  } spi_word_u;

endpackage

//--- common/spi_frame_if.sv
/*
 * Strobes, received frame and response word shared by the receiver, the register file
 * and the MISO shifter. At most one strobe of each kind is high in a given cycle.
 */

interface spi_frame_if;

  // Pulses from the receiver, one clk wide each
  logic sample_stb;
  logic shift_stb;
  logic frame_start;
  logic frame_valid;

  // Word assembled from MOSI, stable from frame_valid until the next frame completes
  spi_pkg::spi_word_u frame;

  // Word the transmitter sends during the next frame
  logic [spi_pkg::frame_bits-1:0] resp;

  // Receiver drives all strobes and the frame
  modport rx (output sample_stb, shift_stb, frame_start, frame_valid, frame);

  // Register file consumes completed frames and produces the response
  modport exec (input frame_valid, frame, output resp);

  // MISO shifter follows the SCLK strobes
  modport tx (input sample_stb, shift_stb, frame_start, resp);

endinterface

//--- spi_slave/spi_frame_rx.sv
/*
 * SPI frame receiver. SCLK, MOSI and CS are asynchronous to clk and are oversampled.
 * Each SCLK half period must last 4 clk or more. Short frames are dropped and bits
 * after the sixteenth are ignored.
 */

module spi_frame_rx (
  input  logic clk,
  input  logic rst,
  input  logic sclk,
  input  logic mosi,
  input  logic cs_n,
  spi_frame_if.rx bus
);

  // Two-flop synchronizers, bit 1 is the usable copy
  logic [1:0] sclk_sync;
  logic [1:0] mosi_sync;
  logic [1:0] cs_sync;

  // Previous values for edge detection
  logic sclk_prev;
  logic cs_sel_prev;

  logic cs_sel;
  logic sclk_rise;
  logic sclk_fall;
  logic sample_edge;
  logic shift_edge;

  // Bits received in the current frame, saturates at frame_bits
  logic [spi_pkg::bit_cnt_bits-1:0] bit_cnt;
  logic [spi_pkg::frame_bits-1:0]   shift_q;
  logic [spi_pkg::frame_bits-1:0]   shift_next;
  logic                             take_bit;

  // ************************************************************
  // Pin synchronization and edge detection
  // ************************************************************

  always_ff @(posedge clk) begin
    if (rst) begin
      sclk_sync <= {2{spi_pkg::cpol}};
      cs_sync   <= {2{~spi_pkg::cs_active_level}};
      sclk_prev <= spi_pkg::cpol;
    end else begin
      sclk_sync <= {sclk_sync[0], sclk};
      cs_sync   <= {cs_sync[0], cs_n};
      sclk_prev <= sclk_sync[1];
    end
  end

  // MOSI is held for a full half period, so it needs no reset
  always_ff @(posedge clk) begin
    mosi_sync <= {mosi_sync[0], mosi};
  end

  assign cs_sel    = (cs_sync[1] == spi_pkg::cs_active_level);
  assign sclk_rise = sclk_sync[1] & ~sclk_prev;
  assign sclk_fall = ~sclk_sync[1] & sclk_prev;

  // Data is sampled on the rising edge when CPOL and CPHA agree, else on the falling one
  assign sample_edge = (spi_pkg::cpol == spi_pkg::cpha) ? sclk_rise : sclk_fall;
  assign shift_edge  = (spi_pkg::cpol == spi_pkg::cpha) ? sclk_fall : sclk_rise;

  // Strobes are registered, which puts them 2 to 3 clk behind the pin edge
  always_ff @(posedge clk) begin
    if (rst) begin
      bus.sample_stb  <= 1'b0;
      bus.shift_stb   <= 1'b0;
      bus.frame_start <= 1'b0;
      cs_sel_prev     <= 1'b0;
    end else begin
      bus.sample_stb  <= cs_sel & sample_edge;
      bus.shift_stb   <= cs_sel & shift_edge;
      bus.frame_start <= cs_sel & ~cs_sel_prev;
      cs_sel_prev     <= cs_sel;
    end
  end

  // ************************************************************
  // Bit counting and frame assembly
  // ************************************************************

  // MOSI is still stable one clk after the sampling strobe
  assign take_bit   = bus.sample_stb && cs_sel && (int'(bit_cnt) < spi_pkg::frame_bits);
  assign shift_next = {shift_q[spi_pkg::frame_bits-2:0], mosi_sync[1]};

  always_ff @(posedge clk) begin
    if (rst) begin
      bit_cnt         <= '0;
      bus.frame_valid <= 1'b0;
    end else begin
      bus.frame_valid <= 1'b0;
      // Releasing CS drops whatever part of a frame was collected
      if (!cs_sel) begin
        bit_cnt <= '0;
      end else if (take_bit) begin
        bit_cnt         <= bit_cnt + 1'b1;
        bus.frame_valid <= (int'(bit_cnt) == spi_pkg::frame_bits - 1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take_bit) begin
      shift_q <= shift_next;
      if (int'(bit_cnt) == spi_pkg::frame_bits - 1) begin
        bus.frame.raw <= shift_next;
      end
    end
  end

endmodule

//--- spi_slave/spi_reg_exec.sv
/*
 * Command execution on a 16-byte register file. Writes above address 15 are dropped
 * and reads there return zero data. The response is ready 1 clk after frame_valid.
 */

module spi_reg_exec (
  input  logic clk,
  input  logic rst,
  spi_frame_if.exec bus
);

  // Completed frame seen through the command view
  spi_pkg::spi_cmd_t cmd;

  // Address falls inside the register file
  logic in_range;

  // Register contents for a read, zero when out of range
  logic [spi_pkg::data_bits-1:0] rd_data;

  // Byte-wide registers at addresses 0 to reg_count-1
  logic [spi_pkg::data_bits-1:0] regs [spi_pkg::reg_count];

  // ************************************************************
  // Command decode
  // ************************************************************

  assign cmd      = bus.frame.cmd;
  assign in_range = int'(cmd.addr) < spi_pkg::reg_count;

  // Only the low address bits index the array, the range check covers the rest
  assign rd_data = in_range ? regs[cmd.addr[spi_pkg::reg_index_bits-1:0]] : '0;

  // ************************************************************
  // Register update and response
  // ************************************************************

  // Registers start at zero, so a read before any write is defined
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < spi_pkg::reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (bus.frame_valid && cmd.wr && in_range) begin
      regs[cmd.addr[spi_pkg::reg_index_bits-1:0]] <= cmd.data;
    end
  end

  // The response waits in resp until the transmitter loads it at the next CS
  always_ff @(posedge clk) begin
    if (rst) begin
      bus.resp <= spi_pkg::default_miso_word;
    end else if (bus.frame_valid) begin
      if (cmd.wr) begin
        // A write has nothing to report
        bus.resp <= spi_pkg::default_miso_word;
      end else begin
        // Read echo is a zero bit, the address, then the data byte
        bus.resp <= {1'b0, cmd.addr, rd_data};
      end
    end
  end

endmodule

//--- spi_slave/spi_frame_tx.sv
/*
 * MISO shifter. The response is loaded when CS becomes active and the last bit is held
 * until CS is released. MISO is always driven since no tristate is modelled.
 */

module spi_frame_tx (
  input  logic clk,
  input  logic rst,
  input  logic cs_n,
  output logic miso,
  spi_frame_if.tx bus
);

  // Outgoing word, MSB is on the pin
  logic [spi_pkg::frame_bits-1:0] shift_q;

  // Shifts done in this frame, stops one short of the frame length
  logic [spi_pkg::bit_cnt_bits-1:0] shift_cnt;

  // Set once the master has taken the first bit
  logic sampled_q;

  // Frame in progress and shift register owns the pin
  logic busy_q;

  logic cs_sel;
  logic shift_en;

  assign cs_sel = (cs_n == spi_pkg::cs_active_level);

  // With CPHA 1 the first shift edge leads the first sample and must not move the data,
  // so shifting waits for a sample. With CPHA 0 a sample always comes first anyway
  assign shift_en = busy_q && bus.shift_stb && sampled_q &&
                    (int'(shift_cnt) < spi_pkg::frame_bits - 1);

  // ************************************************************
  // Frame control
  // ************************************************************

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q    <= 1'b0;
      sampled_q <= 1'b0;
      shift_cnt <= '0;
    end else if (bus.frame_start) begin
      busy_q    <= 1'b1;
      sampled_q <= 1'b0;
      shift_cnt <= '0;
    end else if (!cs_sel) begin
      busy_q <= 1'b0;
    end else begin
      if (bus.sample_stb) begin
        sampled_q <= 1'b1;
      end
      if (shift_en) begin
        shift_cnt <= shift_cnt + 1'b1;
      end
    end
  end

  // ************************************************************
  // Output shift register
  // ************************************************************

  always_ff @(posedge clk) begin
    if (bus.frame_start) begin
      shift_q <= bus.resp;
    end else if (shift_en) begin
      shift_q <= {shift_q[spi_pkg::frame_bits-2:0], 1'b0};
    end
  end

  // Between CS going active and frame_start the pending MSB is already on the pin,
  // which covers the synchronizer delay for CPHA 0
  assign miso = (cs_sel && busy_q) ? shift_q[spi_pkg::frame_bits-1]
                                   : bus.resp[spi_pkg::frame_bits-1];

endmodule

//--- hdl/spi_slave_top.sv
/*
 * SPI register slave top level. SPI pins are asynchronous to clk and are oversampled,
 * so SCLK half periods and CS gaps must each span 4 clk or more.
 */

module spi_slave_top (
  input  logic clk,
  input  logic rst,
  input  logic sclk,
  input  logic mosi,
  input  logic cs_n,
  output logic miso
);

  // Strobes, frame and response between the three blocks
  spi_frame_if bus ();

  // ************************************************************
  // Receive, execute, transmit
  // ************************************************************

  // Pin synchronization and frame assembly
  spi_frame_rx spi_frame_rx_i (
    .clk  (clk),
    .rst  (rst),
    .sclk (sclk),
    .mosi (mosi),
    .cs_n (cs_n),
    .bus  (bus.rx)
  );

  // Register file and response forming
  spi_reg_exec spi_reg_exec_i (
    .clk (clk),
    .rst (rst),
    .bus (bus.exec)
  );

  // MISO output shifter
  spi_frame_tx spi_frame_tx_i (
    .clk  (clk),
    .rst  (rst),
    .cs_n (cs_n),
    .miso (miso),
    .bus  (bus.tx)
  );

endmodule

//--- test/tb_clock_gen.sv
/*
 * Testbench clock and reset. The clock period is 100 ns and reset is held high for
 * 8 rising edges, then released on a falling edge.
 */

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int reset_cycles = 8;

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Released on a falling edge, the same edge the stimulus uses
  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

//--- test/spi_slave_checker.sv
/*
 * Protocol checks bound into the frame receiver. Samples on the rising clk edge and
 * sees the receiver's synchronized chip select.
 */

module spi_slave_checker (
  input logic clk,
  input logic rst,
  input logic cs_sel,
  input logic sample_stb,
  input logic shift_stb,
  input logic frame_start,
  input logic frame_valid
);

  timeunit 1ns;
  timeprecision 100ps;

  // A completed frame is reported by a single-cycle pulse
  frame_valid_single: assert property (@(posedge clk) disable iff (rst)
    frame_valid |=> !frame_valid)
    else $error("frame_valid stayed high for more than one cycle");

  // A frame can only complete while the slave is selected
  frame_valid_selected: assert property (@(posedge clk) disable iff (rst)
    frame_valid |-> cs_sel)
    else $error("frame_valid rose while chip select was inactive");

  // Strobes are registered, so they are clear one cycle into reset
  strobes_in_reset: assert property (@(posedge clk)
    rst |=> !(sample_stb || shift_stb || frame_start || frame_valid))
    else $error("strobe high while reset was applied");

endmodule

//--- test/spi_slave_tb.sv
/*
 * Testbench for the SPI register slave. Acts as a mode 0 master with an active-low CS,
 * changes pins on the falling clk edge and checks every MISO word against a register model.
 */

module spi_slave_tb;

  timeunit 1ns;
  timeprecision 100ps;

  // ************************************************************
  // Timing of the master
  // ************************************************************

  // Each SCLK half period and the CS gap in clk cycles
  localparam int half_period = 4;
  localparam int gap_clks    = 6;

  // One frame is 33 half periods with CS low plus the gap, 138 clk
  localparam int frame_clks = half_period * (2 * spi_pkg::frame_bits + 1) + gap_clks;

  // About twice the length of 60 frames, rounded up to whole ten thousands
  localparam int timeout_frames = 60;
  localparam int timeout_clks   = ((2 * timeout_frames * frame_clks + 9999) / 10000) * 10000;

  logic clk;
  logic rst;
  logic sclk;
  logic mosi;
  logic cs_n;
  logic miso;
  int   cycle_cnt;

  // Register model and the response the DUT owes for the next frame
  logic [spi_pkg::data_bits-1:0] model_regs [spi_pkg::reg_count];
  spi_pkg::spi_word_u            pending;

  // Words waiting for the compare process
  spi_pkg::spi_word_u exp_q [$];
  spi_pkg::spi_word_u act_q [$];
  string              name_q [$];

  tb_clock_gen clock_gen_i (
    .clk (clk),
    .rst (rst)
  );

  spi_slave_top spi_slave_top_i (
    .clk  (clk),
    .rst  (rst),
    .sclk (sclk),
    .mosi (mosi),
    .cs_n (cs_n),
    .miso (miso)
  );

  bind spi_frame_rx spi_slave_checker spi_slave_checker_i (
    .clk         (clk),
    .rst         (rst),
    .cs_sel      (cs_sel),
    .sample_stb  (bus.sample_stb),
    .shift_stb   (bus.shift_stb),
    .frame_start (bus.frame_start),
    .frame_valid (bus.frame_valid)
  );

  // ************************************************************
  // Reference model and checks
  // ************************************************************

  // Returns the word expected on MISO during this frame and applies the command to the model
  function automatic spi_pkg::spi_word_u predict_response(input spi_pkg::spi_word_u word);
    spi_pkg::spi_word_u            expected;
    logic [spi_pkg::data_bits-1:0] rd_byte;
    logic                          in_range;
    expected = pending;
    in_range = int'(word.cmd.addr) < spi_pkg::reg_count;
    if (word.cmd.wr) begin
      if (in_range) begin
        model_regs[word.cmd.addr[3:0]] = word.cmd.data;
      end
      pending.raw = spi_pkg::default_miso_word;
    end else begin
      rd_byte     = in_range ? model_regs[word.cmd.addr[3:0]] : 8'h00;
      pending.raw = {1'b0, word.cmd.addr, rd_byte};
    end
    return expected;
  endfunction

  task automatic check_word(input string name, input spi_pkg::spi_word_u expected,
                            input spi_pkg::spi_word_u actual);
    if (actual.raw !== expected.raw) begin
      $display("ERR %s expected %h actual %h", name, expected.raw, actual.raw);
      $display("Errors found");
      $fatal(1, "MISO word mismatch");
    end
  endtask

  // Pops on the rising edge while the driver pushes on the falling one
  always @(posedge clk) begin
    if (act_q.size() != 0) begin
      check_word(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < timeout_clks) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d clk cycles", timeout_clks);
    $display("Errors found");
    $fatal(1, "Simulation timed out");
  end

  // ************************************************************
  // SPI master
  // ************************************************************

  task automatic wait_clks(input int n);
    repeat (n) @(negedge clk);
  endtask

  // Runs nbits of a frame, nbits below 16 aborts it; MISO is taken at each rising SCLK
  task automatic run_frame(input spi_pkg::spi_word_u word, input int nbits,
                           output spi_pkg::spi_word_u captured);
    captured.raw = '0;
    cs_n         = 1'b0;
    for (int i = 0; i < nbits; i++) begin
      mosi = word.raw[spi_pkg::frame_bits-1-i];
      wait_clks(half_period);
      sclk         = 1'b1;
      captured.raw = {captured.raw[spi_pkg::frame_bits-2:0], miso};
      wait_clks(half_period);
      sclk = 1'b0;
    end
    wait_clks(half_period);
    cs_n = 1'b1;
    mosi = 1'b0;
    wait_clks(gap_clks);
  endtask

  task automatic send_cmd(input string name, input logic wr,
                          input logic [spi_pkg::addr_bits-1:0] addr,
                          input logic [spi_pkg::data_bits-1:0] data);
    spi_pkg::spi_word_u word;
    spi_pkg::spi_word_u expected;
    spi_pkg::spi_word_u captured;
    word.cmd.wr   = wr;
    word.cmd.addr = addr;
    word.cmd.data = data;
    expected      = predict_response(word);
    run_frame(word, spi_pkg::frame_bits, captured);
    name_q.push_back(name);
    exp_q.push_back(expected);
    act_q.push_back(captured);
  endtask

  // Half a frame, which the DUT must discard along with its MISO bits
  task automatic abort_cmd(input logic wr, input logic [spi_pkg::addr_bits-1:0] addr,
                           input logic [spi_pkg::data_bits-1:0] data);
    spi_pkg::spi_word_u word;
    spi_pkg::spi_word_u captured;
    word.cmd.wr   = wr;
    word.cmd.addr = addr;
    word.cmd.data = data;
    run_frame(word, spi_pkg::frame_bits / 2, captured);
  endtask

  // ************************************************************
  // Test sequence
  // ************************************************************

  initial begin
    logic                          rnd_wr;
    logic [spi_pkg::addr_bits-1:0] rnd_addr;
    logic [spi_pkg::data_bits-1:0] rnd_data;
    sclk = spi_pkg::cpol;
    mosi = 1'b0;
    cs_n = 1'b1;
    void'($urandom(32'hf69f144a));
    pending.raw = spi_pkg::default_miso_word;
    for (int i = 0; i < spi_pkg::reg_count; i++) begin
      model_regs[i] = '0;
    end
    @(negedge rst);
    wait_clks(half_period);

    // Nothing is pending after reset
    send_cmd("first_after_reset", 1'b0, 7'd3, 8'h00);

    // Write then read back, the read result arrives one frame later
    send_cmd("write_5", 1'b1, 7'd5, 8'h3c);
    send_cmd("read_5_after_write", 1'b0, 7'd5, 8'h00);
    send_cmd("read_5_result", 1'b0, 7'd9, 8'h00);

    // Out of range write is dropped and must not alias onto address 0
    send_cmd("write_32", 1'b1, 7'd32, 8'h77);
    // Address 37 shares its low bits with the nonzero register 5 and still reads zero
    send_cmd("read_37", 1'b0, 7'd37, 8'h00);
    send_cmd("read_0", 1'b0, 7'd0, 8'h00);
    send_cmd("read_0_result", 1'b0, 7'd5, 8'h00);

    // Abort a write after 8 bits, the pending read of 5 must survive it
    abort_cmd(1'b1, 7'd5, 8'hee);
    send_cmd("after_abort", 1'b0, 7'd5, 8'h00);
    send_cmd("reg_5_kept", 1'b0, 7'd7, 8'h00);

    // Mostly in range, a quarter anywhere in the 7-bit space
    for (int n = 0; n < 40; n++) begin
      rnd_wr   = 1'($urandom_range(1, 0));
      rnd_addr = ($urandom_range(3, 0) == 0) ? 7'($urandom_range(127, 0))
                                             : 7'($urandom_range(15, 0));
      rnd_data = 8'($urandom_range(255, 0));
      send_cmd($sformatf("random_%0d", n), rnd_wr, rnd_addr, rnd_data);
    end

    // Collects the response to the last random command
    send_cmd("final_flush", 1'b0, 7'd0, 8'h00);
    wait_clks(2);

    if (act_q.size() != 0) begin
      $display("Captured MISO words were left unchecked at the end of the run");
      $display("Errors found");
      $fatal(1, "Unchecked words");
    end else begin
      $display("No errors");
      $finish;
    end
  end

endmodule

//--- files.f
common/spi_pkg.sv
common/spi_frame_if.sv
spi_slave/spi_frame_rx.sv
spi_slave/spi_reg_exec.sv
spi_slave/spi_frame_tx.sv
hdl/spi_slave_top.sv
test/tb_clock_gen.sv
test/spi_slave_checker.sv
test/spi_slave_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = spi_slave_tb
FILELIST = files.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^No errors$$" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
